//--- include/jstk_consts.svh
`ifndef JSTK_CONSTS_SVH
`define JSTK_CONSTS_SVH

// SPI timing in CLK cycles
`define JSTK_SCLK_HALF      4       // CLK cycles per SCLK half period
`define JSTK_POLL_CYCLES    2000    // Frame start to frame start

// Frame contents
`define JSTK_FRAME_BYTES    5       // Bytes per joystick frame
`define JSTK_CMD_BYTE       8'h80   // Sent in every byte slot

// Direction thresholds
`define JSTK_LEFT_MIN       550     // x at or above means left
`define JSTK_RIGHT_MAX      450     // x at or below means right
`define JSTK_Y_LOW          320     // Lower edge of the y window
`define JSTK_Y_HIGH         720     // Upper edge of the y window

`endif

//--- src/jstkPkg.sv
package jstkPkg;

	// ========================================================================
	// Data types shared by the joystick datapath
	// ========================================================================

	// One byte on the SPI wire
	typedef logic [7:0] spiByteT;

	// Axis reading as the module reports it
	typedef logic [9:0] axisT;

	// Steering direction, encoding matches the
	// two-bit code driven off chip
	typedef enum logic [1:0] {
		STRAIGHT = 2'd0,
		LEFT     = 2'd1,
		BACK     = 2'd2,
		RIGHT    = 2'd3
	} directionT;

endpackage

//--- src/byteLink.sv
`timescale 1ns/1ps

// Byte request handshake between frame controller and SPI engine
interface byteLink import jstkPkg::*; ();

	logic    start;   // One-cycle transfer request
	spiByteT txByte;  // Byte to shift out on MOSI
	logic    busy;    // High while a byte is on the wire
	spiByteT rxByte;  // Last byte shifted in from MISO

	// Frame controller side
	modport ctrl (
		output start,
		output txByte,
		input  busy,
		input  rxByte
	);

	// SPI engine side
	modport engine (
		input  start,
		input  txByte,
		output busy,
		output rxByte
	);

endinterface

//--- src/spiByteEngine.sv
`timescale 1ns/1ps
`include "jstk_consts.svh"

module spiByteEngine import jstkPkg::*; (
	input  logic   CLK,
	input  logic   RST,
	byteLink.engine link,
	input  logic   MISO,
	output logic   SCLK,
	output logic   MOSI
);

	// ========================================================================
	// Mode-0 byte shifter, SCLK made from CLK by a half-period counter
	// ========================================================================

	localparam int HalfW = $clog2(`JSTK_SCLK_HALF + 1);

	logic [HalfW-1:0] halfCnt;    // CLK cycles into current half period
	logic [3:0]       bitCnt;     // Falling edges seen so far
	logic             sclkPhase;  // Internal copy of SCLK
	logic             busyReg;
	spiByteT          txShift;    // MSB drives MOSI
	spiByteT          rxShift;    // Fills from the LSB end
	logic             halfDone;

	assign halfDone = (halfCnt == HalfW'(`JSTK_SCLK_HALF - 1));

	// Outputs straight from registers
	assign SCLK        = sclkPhase;
	assign MOSI        = txShift[7];  // MSB first
	assign link.busy   = busyReg;
	assign link.rxByte = rxShift;     // Stable until next start

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			halfCnt   <= '0;
			bitCnt    <= '0;
			sclkPhase <= 1'b0;
			busyReg   <= 1'b0;
			txShift   <= '0;  // Keeps MOSI low out of reset
		end else if (!busyReg) begin
			// Idle, clock parked low
			halfCnt   <= '0;
			bitCnt    <= '0;
			sclkPhase <= 1'b0;
			if (link.start) begin
				busyReg <= 1'b1;
				txShift <= link.txByte;  // First bit on MOSI ahead of first rise
			end
		end else if (bitCnt == 4'd8) begin
			busyReg <= 1'b0;  // Extra cycle after eighth fall, then done
		end else if (halfDone) begin
			halfCnt   <= '0;
			sclkPhase <= ~sclkPhase;
			if (!sclkPhase) begin
				// Rising edge
			end else begin
				// Falling edge, next bit out
				txShift <= {txShift[6:0], 1'b0};
				bitCnt  <= bitCnt + 4'd1;
			end
		end else begin
			halfCnt <= halfCnt + HalfW'(1);
		end
	end

	// Receive side, no reset on the payload
	always_ff @(posedge CLK) begin
		if (busyReg && halfDone && !sclkPhase && bitCnt != 4'd8)
			rxShift <= {rxShift[6:0], MISO};  // Sample on SCLK rise
	end

endmodule

//--- src/jstkPacketCtrl.sv
`timescale 1ns/1ps
`include "jstk_consts.svh"

module jstkPacketCtrl import jstkPkg::*; (
	input  logic   CLK,
	input  logic   RST,
	byteLink.ctrl  link,
	output logic   SS,
	output axisT   xAxis,
	output axisT   yAxis,
	output logic   sampleValid
);

	// ========================================================================
	// Poll timer, five-byte frame sequencer and axis decode
	// ========================================================================

	localparam int PollW = $clog2(`JSTK_POLL_CYCLES);
	localparam int HalfW = $clog2(`JSTK_SCLK_HALF + 1);
	localparam int CntW  = $clog2(`JSTK_FRAME_BYTES + 1);

	typedef enum logic [2:0] {
		stIdle,
		stSelect,   // SS low, lead-in half period
		stRequest,  // start high for this one cycle
		stWait,     // Byte on the wire
		stGap,      // Half period between bytes
		stRelease   // Publish axes, raise SS
	} ctrlStateT;

	ctrlStateT        state;
	logic [PollW-1:0] pollCnt;
	logic             pollTick;
	logic [HalfW-1:0] halfCnt;
	logic             halfDone;
	logic [CntW-1:0]  byteCnt;
	logic [39:0]      frame;     // First byte ends up in the top octet

	assign pollTick = (pollCnt == PollW'(`JSTK_POLL_CYCLES - 1));
	assign halfDone = (halfCnt == HalfW'(`JSTK_SCLK_HALF - 1));

	assign link.start  = (state == stRequest);
	assign link.txByte = spiByteT'(`JSTK_CMD_BYTE);  // Same command every slot

	// Free-running poll timer
	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			pollCnt <= '0;
		else if (pollTick)
			pollCnt <= '0;
		else
			pollCnt <= pollCnt + PollW'(1);
	end

	// Frame FSM
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state       <= stIdle;
			SS          <= 1'b1;
			halfCnt     <= '0;
			byteCnt     <= '0;
			sampleValid <= 1'b0;
			xAxis       <= '0;
			yAxis       <= '0;
		end else begin
			sampleValid <= 1'b0;  // Single-cycle pulse
			case (state)
				stIdle: begin
					byteCnt <= '0;
					if (pollTick) begin
						SS    <= 1'b0;
						state <= stSelect;
					end
				end
				stSelect: begin
					if (halfDone) begin
						halfCnt <= '0;
						state   <= stRequest;
					end else begin
						halfCnt <= halfCnt + HalfW'(1);
					end
				end
				stRequest: state <= stWait;  // Engine sees start on this edge
				stWait: begin
					if (!link.busy) begin
						byteCnt <= byteCnt + CntW'(1);
						state   <= stGap;
					end
				end
				stGap: begin
					if (halfDone) begin
						halfCnt <= '0;
						if (byteCnt == CntW'(`JSTK_FRAME_BYTES))
							state <= stRelease;
						else
							state <= stRequest;
					end else begin
						halfCnt <= halfCnt + HalfW'(1);
					end
				end
				stRelease: begin
					SS          <= 1'b1;
					sampleValid <= 1'b1;
					// Byte 1 low y, byte 2 high y, byte 3 low x, byte 4 high x
					yAxis       <= {frame[25:24], frame[39:32]};
					xAxis       <= {frame[9:8], frame[23:16]};
					state       <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Received bytes, shifted in as each one completes
	always_ff @(posedge CLK) begin
		if (state == stWait && !link.busy)
			frame <= {frame[31:0], link.rxByte};
	end

endmodule

//--- src/directionClassifier.sv
`timescale 1ns/1ps
`include "jstk_consts.svh"

module directionClassifier import jstkPkg::*; (
	input  logic      CLK,
	input  logic      RST,
	input  axisT      xAxis,
	input  axisT      yAxis,
	input  logic      sampleValid,
	output directionT direction
);

	// ========================================================================
	// Threshold compare against the sampled stick position
	// ========================================================================

	logic yInWindow;  // y inside the left/right band
	logic xLeft;
	logic xRight;

	assign yInWindow = (yAxis >= axisT'(`JSTK_Y_LOW)) && (yAxis <= axisT'(`JSTK_Y_HIGH));
	assign xLeft     = (xAxis >= axisT'(`JSTK_LEFT_MIN));
	assign xRight    = (xAxis <= axisT'(`JSTK_RIGHT_MAX));

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			direction <= STRAIGHT;
		end else if (sampleValid) begin
			// Priority order, sideways wins over forward/back
			if (xLeft && yInWindow)
				direction <= LEFT;
			else if (xRight && yInWindow)
				direction <= RIGHT;
			else if (yAxis < axisT'(`JSTK_Y_LOW))
				direction <= STRAIGHT;
			else if (yAxis > axisT'(`JSTK_Y_HIGH))
				direction <= BACK;
			// Dead zone keeps last direction
		end
	end

endmodule

//--- src/pmodJstkTop.sv
`timescale 1ns/1ps

module pmodJstkTop (
	input  logic       CLK,
	input  logic       RST,
	input  logic       MISO,         // From joystick
	output logic       SS,           // Active low select
	output logic       SCLK,
	output logic       MOSI,
	output logic [9:0] xAxis,
	output logic [9:0] yAxis,
	output logic       sampleValid,  // One pulse per frame
	output logic [1:0] direction
);

	// ========================================================================
	// Engine, frame controller and classifier
	// ========================================================================

	byteLink link ();

	// SPI wire side
	spiByteEngine uEngine (
		.CLK  (CLK),
		.RST  (RST),
		.link (link),
		.MISO (MISO),
		.SCLK (SCLK),
		.MOSI (MOSI)
	);

	// Framing and axis decode
	jstkPacketCtrl uCtrl (
		.CLK         (CLK),
		.RST         (RST),
		.link        (link),
		.SS          (SS),
		.xAxis       (xAxis),
		.yAxis       (yAxis),
		.sampleValid (sampleValid)
	);

	// Steering output
	directionClassifier uClassifier (
		.CLK         (CLK),
		.RST         (RST),
		.xAxis       (xAxis),
		.yAxis       (yAxis),
		.sampleValid (sampleValid),
		.direction   (direction)
	);

endmodule

//--- verif/jstkSlaveModel.sv
`timescale 1ns/1ps

module jstkSlaveModel import jstkPkg::*; (
	input  logic        SS,
	input  logic        SCLK,
	input  logic        MOSI,
	input  logic [39:0] txFrame,    // Byte 1 in the top octet
	output logic        MISO,
	output logic [39:0] rxFrame,    // MOSI bits, first bit ends up on top
	output int          riseCount   // SCLK rises seen in the current frame
);

	// ========================================================================
	// Joystick side of the SPI wire, mode 0
	// ========================================================================

	logic [39:0] misoShift;

	// Reply bits, first one ready as soon as SS falls
	initial begin
		MISO      = 1'b0;
		misoShift = '0;
		forever begin
			@(negedge SS);
			misoShift = txFrame;  // Row latched at frame start
			MISO      = misoShift[39];
			while (!SS) begin
				@(negedge SCLK or posedge SS);
				if (!SS) begin
					misoShift = {misoShift[38:0], 1'b0};  // Next bit after each fall
					MISO      = misoShift[39];
				end
			end
		end
	end

	// Command capture on rising SCLK
	initial begin
		rxFrame   = '0;
		riseCount = 0;
		forever begin
			@(negedge SS);
			riseCount = 0;
			while (!SS) begin
				@(posedge SCLK or posedge SS);
				if (!SS) begin
					rxFrame   = {rxFrame[38:0], MOSI};
					riseCount = riseCount + 1;
				end
			end
		end
	end

endmodule

//--- verif/tbPmodJstk.sv
`timescale 1ns/1ps
`include "jstk_consts.svh"

module tbPmodJstk import jstkPkg::*; ();

	// ========================================================================
	// Stimulus table with one frame per row
	// ========================================================================

	typedef struct packed {
		axisT      y;
		axisT      x;
		directionT dir;  // Expected after this frame
	} rowT;

	localparam int      NumRows       = 18;
	localparam int      TimeoutCycles = (NumRows + 2) * `JSTK_POLL_CYCLES;
	localparam int      FrameBytes    = 5;      // Bytes per joystick frame
	localparam int      FrameRises    = 8 * FrameBytes;
	localparam spiByteT CmdByte       = 8'h80;  // Read command in every slot

	localparam rowT TestRows [NumRows] = '{
		'{10'd100,  10'd500,  STRAIGHT},  // Forward region
		'{10'd900,  10'd500,  BACK},
		'{10'd500,  10'd800,  LEFT},
		'{10'd500,  10'd450,  RIGHT},     // Right edge
		'{10'd500,  10'd549,  RIGHT},     // Just short of left so it holds
		'{10'd500,  10'd550,  LEFT},      // Left edge
		'{10'd500,  10'd451,  LEFT},      // Just short of right so it holds
		'{10'd500,  10'd100,  RIGHT},
		'{10'd320,  10'd600,  LEFT},      // Low window edge
		'{10'd319,  10'd600,  STRAIGHT},
		'{10'd720,  10'd600,  LEFT},      // High window edge
		'{10'd721,  10'd600,  BACK},
		'{10'd500,  10'd500,  BACK},      // Dead zone
		'{10'd319,  10'd100,  STRAIGHT},
		'{10'd721,  10'd100,  BACK},
		'{10'd0,    10'd1023, STRAIGHT},
		'{10'd400,  10'd1023, LEFT},
		'{10'd500,  10'd500,  LEFT}       // Dead zone again
	};

	logic        CLK;
	logic        RST;
	logic        MISO;
	logic        SS;
	logic        SCLK;
	logic        MOSI;
	logic [9:0]  xAxis;
	logic [9:0]  yAxis;
	logic        sampleValid;
	logic [1:0]  direction;
	logic [39:0] txFrame;    // Bytes the slave plays back
	logic [39:0] rxFrame;    // Bytes the slave heard
	int          riseCount;
	int          cycleCount;

	pmodJstkTop uut (
		.CLK         (CLK),
		.RST         (RST),
		.MISO        (MISO),
		.SS          (SS),
		.SCLK        (SCLK),
		.MOSI        (MOSI),
		.xAxis       (xAxis),
		.yAxis       (yAxis),
		.sampleValid (sampleValid),
		.direction   (direction)
	);

	jstkSlaveModel slave (
		.SS        (SS),
		.SCLK      (SCLK),
		.MOSI      (MOSI),
		.txFrame   (txFrame),
		.MISO      (MISO),
		.rxFrame   (rxFrame),
		.riseCount (riseCount)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;  // 8 ns period
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkLevel(input string name, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("error: %0t ns %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic checkAxis(input string name, input axisT got, input axisT exp);
		if (got !== exp)
			abortRun($sformatf("error: %0t ns %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic checkDirection(input int row, input directionT got, input directionT exp);
		if (got !== exp)
			abortRun($sformatf("error: %0t ns row %0d direction is %s, expected %s",
				$time, row, got.name(), exp.name()));
	endtask

	task automatic checkCmdByte(input int slot, input spiByteT got);
		if (got !== CmdByte)
			abortRun($sformatf("error: %0t ns MOSI byte %0d is %h, expected %h",
				$time, slot, got, CmdByte));
	endtask

	task automatic checkEdgeCount(input int got);
		if (got != FrameRises)
			abortRun($sformatf("error: %0t ns frame had %0d SCLK rises, expected %0d",
				$time, got, FrameRises));
	endtask

	// Reset values of the observable outputs
	task automatic checkResetState();
		checkLevel("SS", SS, 1'b1);
		checkLevel("SCLK", SCLK, 1'b0);
		checkLevel("sampleValid", sampleValid, 1'b0);
		checkDirection(-1, directionT'(direction), STRAIGHT);
	endtask

	// Row bytes with random filler in the unused bits
	task automatic loadRow(input rowT row);
		logic [31:0] fill;
		fill    = $urandom;
		txFrame = {row.y[7:0], fill[7:2], row.y[9:8],
			row.x[7:0], fill[13:8], row.x[9:8], fill[21:14]};
	endtask

	// ========================================================================
	// Monitors and timeout
	// ========================================================================

	always @(negedge CLK) begin
		if (!RST && SS && SCLK)
			abortRun($sformatf("SCLK was high while SS was high at %0t ns", $time));
	end

	initial begin
		cycleCount = 0;
		forever begin
			@(posedge CLK);
			cycleCount = cycleCount + 1;
			if (cycleCount >= TimeoutCycles)
				abortRun($sformatf("timeout, no finish after %0d clock cycles", TimeoutCycles));
		end
	end

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		void'($urandom(32'h17933fd2));
		RST     = 1'b1;
		txFrame = '0;
		repeat (5) begin
			@(negedge CLK);
			checkResetState();
		end
		RST = 1'b0;
		@(negedge CLK);
		checkResetState();  // Right after release

		for (int i = 0; i < NumRows; i++) begin
			loadRow(TestRows[i]);  // SS is high here
			@(negedge CLK);
			while (!sampleValid)
				@(negedge CLK);
			checkAxis("yAxis", axisT'(yAxis), TestRows[i].y);
			checkAxis("xAxis", axisT'(xAxis), TestRows[i].x);
			checkLevel("SS", SS, 1'b1);  // Rises with sampleValid
			checkEdgeCount(riseCount);
			for (int b = 0; b < FrameBytes; b++)
				checkCmdByte(b, spiByteT'(rxFrame[39 - 8 * b -: 8]));
			@(negedge CLK);
			checkDirection(i, directionT'(direction), TestRows[i].dir);
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
src/jstkPkg.sv
src/byteLink.sv
src/spiByteEngine.sv
src/jstkPacketCtrl.sv
src/directionClassifier.sv
src/pmodJstkTop.sv
verif/jstkSlaveModel.sv
verif/tbPmodJstk.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tbPmodJstk
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
